//--- Makefile
SIM := obj_dir/Vtb_debug_unit

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard hdl/*.sv test/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f filelist.f --top-module tb_debug_unit -o Vtb_debug_unit

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+include
hdl/debug_pkg.sv
hdl/dump_req_if.sv
hdl/debug_ctrl.sv
hdl/dump_serializer.sv
hdl/dump_fifo.sv
hdl/uart_tx.sv
hdl/debug_unit_top.sv
test/tb_debug_unit.sv

//--- hdl/debug_ctrl.sv
`include "debug_macros.svh"

module debug_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic [`DBG_PROG_AW-1:0] prog_addr,
    output logic [`DBG_DATA_W-1:0]  prog_data,
    output logic                    prog_we,
    output logic                    cpu_reset,
    output logic                    cpu_run,
    input  logic                    halt,
    dump_req_if.ctrl                dump
);

    debug_pkg::ctrl_state_e state;
    debug_pkg::dbg_cmd_e    cmd;
    logic [1:0]             byte_cnt;
    logic                   step_run;   // Single step clock enable
    logic                   req_q;
    logic [`DBG_DATA_W-1:0] cycle_cnt;

    assign cmd = debug_pkg::dbg_cmd_e'(rx_data);

    assign cpu_reset = (state == debug_pkg::IDLE) || (state == debug_pkg::LOAD) ||
                       (state == debug_pkg::WAITING);
    assign cpu_run   = ((state == debug_pkg::CONTINUOUS) && !halt) ||
                       ((state == debug_pkg::STEP_MODE) && step_run);

    assign dump.req    = req_q;
    assign dump.halted = halt;
    assign dump.cycles = cycle_cnt;

    // Words assemble LSB first
    always_ff @(posedge clk) begin
        if (state == debug_pkg::LOAD && rx_valid)
            prog_data <= {rx_data, prog_data[`DBG_DATA_W-1:8]};
    end

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= debug_pkg::WAITING;
            byte_cnt  <= '0;
            prog_addr <= '0;
            prog_we   <= 1'b0;
            step_run  <= 1'b0;
            req_q     <= 1'b0;
            cycle_cnt <= '0;
        end else begin
            prog_we  <= 1'b0;
            step_run <= 1'b0;
            req_q    <= 1'b0;
            if (prog_we)
                prog_addr <= prog_addr + 1'b1;
            if (cpu_run)
                cycle_cnt <= cycle_cnt + 1'b1;

            unique case (state)
                debug_pkg::IDLE: begin
                    if (rx_valid && cmd == debug_pkg::CMD_LOAD) begin
                        state     <= debug_pkg::LOAD;
                        byte_cnt  <= '0;
                        prog_addr <= '0;
                    end
                end
                debug_pkg::LOAD: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3)
                            prog_we <= 1'b1;
                    end
                    if (prog_we && &prog_data[`DBG_DATA_W-1:`DBG_DATA_W-6])
                        state <= debug_pkg::WAITING;   // Halt word written
                end
                debug_pkg::WAITING: begin
                    cycle_cnt <= '0;
                    if (rx_valid) begin
                        case (cmd)
                            debug_pkg::CMD_LOAD: begin
                                state     <= debug_pkg::LOAD;
                                byte_cnt  <= '0;
                                prog_addr <= '0;
                            end
                            debug_pkg::CMD_REPROG:    state <= debug_pkg::IDLE;
                            debug_pkg::CMD_CONT:      state <= debug_pkg::CONTINUOUS;
                            debug_pkg::CMD_STEP_MODE: state <= debug_pkg::STEP_MODE;
                            default: ;
                        endcase
                    end
                end
                debug_pkg::STEP_MODE: begin
                    if (step_run) begin
                        state <= debug_pkg::DUMP;
                        req_q <= 1'b1;
                    end else if (rx_valid && cmd == debug_pkg::CMD_STEP) begin
                        step_run <= 1'b1;
                    end
                end
                debug_pkg::CONTINUOUS: begin
                    if (halt) begin
                        state <= debug_pkg::DUMP;
                        req_q <= 1'b1;
                    end
                end
                debug_pkg::DUMP: begin  // Host bytes ignored here
                    if (dump.done)
                        state <= halt ? debug_pkg::WAITING : debug_pkg::STEP_MODE;
                end
                default: state <= debug_pkg::WAITING;
            endcase
        end
    end

    // One step clock, then the dump request
    a_step_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (state == debug_pkg::STEP_MODE && cpu_run) |=> (dump.req && !cpu_run));

    a_we_state: assert property (@(posedge clk) disable iff (reset)
        prog_we |-> (state == debug_pkg::LOAD));

endmodule

//--- hdl/debug_pkg.sv
`include "debug_macros.svh"

package debug_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        WAITING,
        STEP_MODE,
        CONTINUOUS,
        DUMP
    } ctrl_state_e;

    // Host opcodes
    typedef enum logic [7:0] {
        CMD_LOAD      = `DBG_CMD_LOAD,
        CMD_CONT      = `DBG_CMD_CONT,
        CMD_STEP_MODE = `DBG_CMD_STEP_MODE,
        CMD_REPROG    = `DBG_CMD_REPROG,
        CMD_STEP      = `DBG_CMD_STEP
    } dbg_cmd_e;

    typedef enum logic [2:0] {
        HEADER,
        PC,
        CYCLES,
        REGS,
        DONE    // Also the idle phase
    } dump_phase_e;

endpackage

//--- hdl/debug_unit_top.sv
`include "debug_macros.svh"

module debug_unit_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    output logic                    tx,
    output logic [`DBG_PROG_AW-1:0] prog_addr,
    output logic [`DBG_DATA_W-1:0]  prog_data,
    output logic                    prog_we,
    output logic                    cpu_reset,
    output logic                    cpu_run,
    input  logic                    halt,
    input  logic [`DBG_DATA_W-1:0]  pc,
    output logic [`DBG_REG_AW-1:0]  reg_addr,
    input  logic [`DBG_DATA_W-1:0]  reg_data
);

    logic [7:0] ser_data;
    logic       ser_valid;
    logic       ser_ready;
    logic [7:0] fifo_data;
    logic       fifo_valid;
    logic       fifo_ready;

    dump_req_if u_dump_if ();

    debug_ctrl u_ctrl (
        .clk, .reset, .rx_data, .rx_valid,
        .prog_addr, .prog_data, .prog_we,
        .cpu_reset, .cpu_run, .halt,
        .dump (u_dump_if.ctrl)
    );

    dump_serializer u_ser (
        .clk, .reset,
        .dump  (u_dump_if.ser),
        .pc, .reg_addr, .reg_data,
        .data  (ser_data),
        .valid (ser_valid),
        .ready (ser_ready)
    );

    dump_fifo u_fifo (
        .clk, .reset,
        .in_data   (ser_data),
        .in_valid  (ser_valid),
        .in_ready  (ser_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    uart_tx u_tx (
        .clk, .reset,
        .data  (fifo_data),
        .valid (fifo_valid),
        .ready (fifo_ready),
        .tx
    );

endmodule

//--- hdl/dump_fifo.sv
`include "debug_macros.svh"

module dump_fifo (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int AW = $clog2(`DBG_FIFO_DEPTH);

    logic [7:0]  mem [`DBG_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign in_ready  = (count != (AW+1)'(`DBG_FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Overflow or underflow pushes count out of range
    a_count_range: assert property (@(posedge clk) disable iff (reset)
        count <= (AW+1)'(`DBG_FIFO_DEPTH));
    a_ptr_count: assert property (@(posedge clk) disable iff (reset)
        AW'(wr_ptr - rd_ptr) == count[AW-1:0]);

endmodule

//--- hdl/dump_req_if.sv
`include "debug_macros.svh"

interface dump_req_if;
    logic                   req;
    logic                   halted;
    logic [`DBG_DATA_W-1:0] cycles;
    logic                   done;

    modport ctrl (
        output req,
        output halted,
        output cycles,
        input  done
    );

    modport ser (
        input  req,
        input  halted,
        input  cycles,
        output done
    );
endinterface

//--- hdl/dump_serializer.sv
`include "debug_macros.svh"

module dump_serializer (
    input  logic                    clk,
    input  logic                    reset,
    dump_req_if.ser                 dump,
    input  logic [`DBG_DATA_W-1:0]  pc,
    output logic [`DBG_REG_AW-1:0]  reg_addr,
    input  logic [`DBG_DATA_W-1:0]  reg_data,
    output logic [7:0]              data,
    output logic                    valid,
    input  logic                    ready
);

    debug_pkg::dump_phase_e phase;
    logic [1:0]             byte_idx;
    logic [`DBG_REG_AW-1:0] reg_cnt;
    logic                   halted_q;
    logic [`DBG_DATA_W-1:0] cycles_q;
    logic [`DBG_DATA_W-1:0] word;
    logic                   done_q;

    assign reg_addr  = reg_cnt;
    assign valid     = (phase != debug_pkg::DONE);
    assign dump.done = done_q;

    always_comb begin
        case (phase)
            debug_pkg::PC:     word = pc;
            debug_pkg::CYCLES: word = cycles_q;
            debug_pkg::REGS:   word = reg_data;
            default:           word = '0;
        endcase
    end

    assign data = (phase == debug_pkg::HEADER) ?
                  (halted_q ? `DBG_HDR_HALTED : `DBG_HDR_STOPPED) :
                  word[{byte_idx, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (dump.req) begin
            halted_q <= dump.halted;
            cycles_q <= dump.cycles;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= debug_pkg::DONE;
            byte_idx <= '0;
            reg_cnt  <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (dump.req) begin
                phase    <= debug_pkg::HEADER;
                byte_idx <= '0;
                reg_cnt  <= '0;
            end else if (valid && ready) begin
                byte_idx <= byte_idx + 1'b1;
                unique case (phase)
                    debug_pkg::HEADER: begin
                        phase    <= debug_pkg::PC;
                        byte_idx <= '0;
                    end
                    debug_pkg::PC:
                        if (byte_idx == 2'd3) phase <= debug_pkg::CYCLES;
                    debug_pkg::CYCLES:
                        if (byte_idx == 2'd3) phase <= debug_pkg::REGS;
                    debug_pkg::REGS: begin
                        if (byte_idx == 2'd3) begin
                            if (reg_cnt == `DBG_REG_AW'(`DBG_NUM_REGS - 1)) begin
                                phase  <= debug_pkg::DONE;
                                done_q <= 1'b1;
                            end else begin
                                reg_cnt <= reg_cnt + 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        (valid && !ready) |=> $stable(data));

endmodule

//--- hdl/uart_tx.sv
`include "debug_macros.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data,
    input  logic       valid,
    output logic       ready,
    output logic       tx
);

    localparam int CW = $clog2(`DBG_CLKS_PER_BIT + 1);

    logic          busy;
    logic [CW-1:0] tick_cnt;    // Clocks within a bit
    logic [3:0]    bit_idx;     // Start, 8 data, stop
    logic [7:0]    shreg;
    logic          bit_end;

    assign ready   = !busy;
    assign bit_end = (tick_cnt == CW'(`DBG_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (valid && ready)
            shreg <= data;
        else if (busy && bit_end)
            shreg <= {1'b1, shreg[7:1]};    // Ones feed the stop bit
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
        end else if (!busy) begin
            if (valid) begin
                busy     <= 1'b1;
                tick_cnt <= '0;
                bit_idx  <= '0;
                tx       <= 1'b0;   // Start bit
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            if (bit_end) begin
                tick_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
                tx       <= shreg[0];
                if (bit_idx == 4'd9)
                    busy <= 1'b0;   // End of stop bit
            end
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        ready |-> tx);

endmodule

//--- include/debug_macros.svh
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

// Sizes
`define DBG_DATA_W        32
`define DBG_NUM_REGS      32
`define DBG_REG_AW        5
`define DBG_PROG_AW       6
`define DBG_FIFO_DEPTH    8
`define DBG_CLKS_PER_BIT  4     // Serial bit time in clocks

// Host command bytes
`define DBG_CMD_LOAD      8'h01
`define DBG_CMD_CONT      8'h02
`define DBG_CMD_STEP_MODE 8'h03
`define DBG_CMD_REPROG    8'h05
`define DBG_CMD_STEP      8'h06

// First byte of a dump
`define DBG_HDR_HALTED    8'hA5
`define DBG_HDR_STOPPED   8'h5A

`endif

//--- test/tb_debug_unit.sv
`include "debug_macros.svh"

module tb_debug_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DUMP_BYTES = 1 + 4 + 4 + 4 * `DBG_NUM_REGS;
    localparam int BYTE_CLKS  = 10 * `DBG_CLKS_PER_BIT;
    localparam int NUM_DUMPS  = 6;
    localparam int LOAD_CLKS  = 400;
    localparam int MAX_CLKS   = 2 * NUM_DUMPS * DUMP_BYTES * BYTE_CLKS + LOAD_CLKS;

    logic                    clk;
    logic                    reset;
    logic [7:0]              rx_data;
    logic                    rx_valid;
    logic                    tx;
    logic [`DBG_PROG_AW-1:0] prog_addr;
    logic [`DBG_DATA_W-1:0]  prog_data;
    logic                    prog_we;
    logic                    cpu_reset;
    logic                    cpu_run;
    logic                    halt;
    logic [`DBG_DATA_W-1:0]  pc = '0;
    logic [`DBG_REG_AW-1:0]  reg_addr;
    logic [`DBG_DATA_W-1:0]  reg_data;
    logic [`DBG_DATA_W-1:0]  halt_pc;
    integer                  seed;
    int                      cycle_cnt;
    logic [7:0]              rx_q[$];      // Bytes seen on tx
    logic [7:0]              exp_q[$];
    logic [31:0]             wr_addr_q[$];
    logic [31:0]             wr_data_q[$];

    debug_unit_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Core model
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (cpu_reset)
            pc <= '0;
        else if (cpu_run)
            pc <= pc + 32'd4;
    end

    assign halt     = (pc == halt_pc);
    assign reg_data = (32'(reg_addr) * 32'h0101_0101) ^ pc;

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > MAX_CLKS)
                stop_with_error($sformatf("timeout, the run did not end in %0d cycles", MAX_CLKS));
        end
    end

    task automatic stop_with_error(string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(logic [31:0] got, logic [31:0] want, string what);
        if (got !== want) begin
            $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic is_halt_word(logic [31:0] w);
        return &w[31:26];
    endfunction

    // Expected dump byte at position idx
    function automatic logic [7:0] dump_byte(int idx, logic [31:0] pc_v, logic halted);
        logic [31:0] w;
        int          wi;
        int          bi;
        if (idx == 0)
            return halted ? `DBG_HDR_HALTED : `DBG_HDR_STOPPED;
        wi = (idx - 1) / 4;
        bi = (idx - 1) % 4;
        if (wi == 0)
            w = pc_v;
        else if (wi == 1)
            w = pc_v / 4;                   // One cycle per instruction
        else
            w = ((wi - 2) * 32'h0101_0101) ^ pc_v;
        return w[bi*8 +: 8];
    endfunction

    task automatic send_byte(logic [7:0] b);
        @(posedge clk);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic send_word(logic [31:0] w);
        int i;
        for (i = 0; i < 4; i++)
            send_byte(w[i*8 +: 8]);
    endtask

    task automatic load_program(int words);
        logic [31:0] w;
        int          i;
        send_byte(debug_pkg::CMD_LOAD);
        for (i = 0; i <= words; i++) begin
            w = $random(seed);
            if (i == words)
                w[31:26] = 6'h3F;           // Halt word closes the program
            else if (is_halt_word(w))
                w[31] = 1'b0;
            wr_addr_q.push_back(i);
            wr_data_q.push_back(w);
            send_word(w);
        end
        while (wr_data_q.size() != 0)
            @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic expect_dump(logic [31:0] pc_v, logic halted);
        int i;
        for (i = 0; i < DUMP_BYTES; i++)
            exp_q.push_back(dump_byte(i, pc_v, halted));
    endtask

    task automatic wait_dump();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    // Samples tx mid-bit
    task automatic receive_byte(output logic [7:0] b);
        int i;
        do
            @(negedge clk);
        while (tx !== 1'b0);
        repeat (`DBG_CLKS_PER_BIT / 2) @(negedge clk);
        if (tx !== 1'b0)
            stop_with_error("start bit on tx too short");
        for (i = 0; i < 8; i++) begin
            repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1)
            stop_with_error("stop bit on tx missing");
    endtask

    initial begin : decode_tx
        logic [7:0] b;
        forever begin
            receive_byte(b);
            rx_q.push_back(b);
        end
    end

    initial begin : compare_bytes
        logic [7:0] got;
        int         idx;
        idx = 0;
        forever begin
            @(negedge clk);
            while (rx_q.size() != 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    stop_with_error("byte on tx while no dump was expected");
                end else begin
                    check(got, exp_q.pop_front(), $sformatf("dump byte %0d", idx));
                    idx = (idx + 1) % DUMP_BYTES;
                end
            end
        end
    end

    initial begin : watch_writes
        forever begin
            @(negedge clk);
            if (prog_we === 1'b1) begin
                if (wr_addr_q.size() == 0) begin
                    stop_with_error("instruction memory write that was not sent");
                end else begin
                    check(prog_addr, wr_addr_q.pop_front(), "write address");
                    check(prog_data, wr_data_q.pop_front(), "write data");
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int k;
        reset    = 1'b1;
        rx_data  = '0;
        rx_valid = 1'b0;
        halt_pc  = 32'd200;
        seed     = 98;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        repeat (20) begin
            @(negedge clk);
            check(cpu_reset, 1, "cpu_reset after reset");
            check(cpu_run, 0, "cpu_run after reset");
            check(prog_we, 0, "prog_we after reset");
            check(tx, 1, "tx idle after reset");
        end

        load_program(10);

        // Continuous run up to the halt pc
        send_byte(debug_pkg::CMD_REPROG);
        load_program(3);
        expect_dump(halt_pc, 1'b1);
        send_byte(debug_pkg::CMD_CONT);
        wait_dump();
        @(negedge clk);
        check(cpu_reset, 1, "cpu_reset after halted dump");

        send_byte(debug_pkg::CMD_STEP_MODE);
        for (k = 1; k <= 3; k++) begin
            expect_dump(4 * k, 1'b0);
            send_byte(debug_pkg::CMD_STEP);
            wait_dump();
            check(pc, 4 * k, "pc after step");
        end

        // Step byte during a dump is dropped
        expect_dump(16, 1'b0);
        send_byte(debug_pkg::CMD_STEP);
        repeat (200) @(posedge clk);
        send_byte(debug_pkg::CMD_STEP);
        wait_dump();
        repeat (3 * BYTE_CLKS) @(negedge clk);
        check(pc, 16, "pc after dropped step");
        expect_dump(20, 1'b0);
        send_byte(debug_pkg::CMD_STEP);
        wait_dump();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
